// File: tb.f
+incdir+verification
common/gb80_pkg.sv
rtl/addr_decode.sv
hram/hram.sv
interrupt/interrupt_ctrl.sv
rtl/ext_mem_port.sv
rtl/gb80_bus_unit.sv
verification/gb80_bus_asserts.sv
verification/tb_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" \
   && verilator --binary --assert -j 0 --top-module tb_top -f tb.f -o tb_top_sim \
   && ./obj_dir/tb_top_sim | grep "TEST RESULT: PASS" \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }

// File: verification/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

   // Pending line and vector from IF, IE and IME
   task automatic check_irq_outputs(input irq_t f, input irq_t e, input logic ime);
      irq_t  pend;
      data_t vec_exp;
      pend    = f & e;
      vec_exp = 8'h00;
      if (pend != '0)
         vec_exp = data_t'(64 + 8 * lowest_bit(pend));
      check_bit("irq_pending", irq_pending, ime && (pend != '0));
      check_byte("vector", vector, vec_exp);
   endtask

   task automatic test_irq_flags();
      irq_t        if_exp;
      irq_t        ie_exp;
      logic [31:0] r;
      int          k;
      read_check(ADDR_IF, 8'h00);
      read_check(ADDR_IE, 8'h00);
      // Only five IE bits are kept
      issue_write(ADDR_IE, 8'hff);
      bus_idle();
      read_check(ADDR_IE, 8'h1f);
      ie_exp = 5'b10110;
      issue_write(ADDR_IE, {3'b111, ie_exp});
      bus_idle();
      if_exp = '0;
      // Random request pulses accumulate in IF
      for (k = 0; k < 8; k++) begin
         r   = rand_bits(5);
         irq = r[4:0];
         next_cycle();
         irq    = '0;
         if_exp = if_exp | r[4:0];
         check_irq_outputs(if_exp, ie_exp, 1'b1);
         read_check(ADDR_IF, {3'b000, if_exp});
      end
   endtask

   task automatic test_irq_ack_mask();
      irq_t if_exp;
      irq_t ie_exp;
      ie_exp = 5'b11111;
      if_exp = 5'b11010;
      issue_write(ADDR_IE, 8'h1f);
      issue_write(ADDR_IF, 8'hfa);
      bus_idle();
      check_irq_outputs(if_exp, ie_exp, 1'b1);
      // Serve requests lowest first until none is left
      while ((if_exp & ie_exp) != '0) begin
         ack = 1'b1;
         next_cycle();
         ack = 1'b0;
         if_exp[lowest_bit(if_exp & ie_exp)] = 1'b0;
         check_irq_outputs(if_exp, ie_exp, 1'b1);
      end
      read_check(ADDR_IF, 8'h00);
      issue_write(ADDR_IF, 8'h05);
      bus_idle();
      if_exp = 5'b00101;
      check_irq_outputs(if_exp, ie_exp, 1'b1);
      // Master disable hides the line, flags stay
      ime_clear = 1'b1;
      next_cycle();
      ime_clear = 1'b0;
      check_irq_outputs(if_exp, ie_exp, 1'b0);
      read_check(ADDR_IF, 8'h05);
      check_irq_outputs(if_exp, ie_exp, 1'b0);
      ime_set = 1'b1;
      next_cycle();
      ime_set = 1'b0;
      check_irq_outputs(if_exp, ie_exp, 1'b1);
      // Bus write overwrites IF
      issue_write(ADDR_IF, 8'h10);
      bus_idle();
      if_exp = 5'b10000;
      check_irq_outputs(if_exp, ie_exp, 1'b1);
      read_check(ADDR_IF, 8'h10);
   endtask

   task automatic test_hram();
      data_t       hdata [HRAM_DEPTH];
      logic [31:0] r;
      int          k;
      int          strobes;
      strobes = ext_strobes;
      for (k = 0; k < HRAM_DEPTH; k++) begin
         r        = rand_bits(8);
         hdata[k] = r[7:0];
         issue_write(HRAM_BASE + addr_t'(k), hdata[k]);
      end
      bus_idle();
      // Back-to-back reads, two in flight
      for (k = 0; k < HRAM_DEPTH; k++)
         issue_read(HRAM_BASE + addr_t'(k), hdata[k]);
      drain();
      assert (ext_strobes == strobes)
         else fail_now("External strobe seen during high RAM accesses");
   endtask

   task automatic test_ext_routing();
      addr_t       wa [N_EXT];
      data_t       wd [N_EXT];
      addr_t       a;
      data_t       exp;
      logic [31:0] r;
      int          k;
      int          j;
      for (k = 0; k < N_EXT; k++) begin
         r     = rand_bits(15);
         // Last write probes the byte just below high RAM
         wa[k] = (k == N_EXT - 1) ? 16'hff7f : {1'b0, r[14:0]};
         r     = rand_bits(8);
         wd[k] = r[7:0];
         issue_write(wa[k], wd[k]);
         check_bit("ext.we", ext.we, 1'b1);
         check_word("ext.addr", ext.addr, wa[k]);
         check_byte("ext.wdata", ext.wdata, wd[k]);
         bus_idle();
         check_bit("ext.we one cycle later", ext.we, 1'b0);
      end
      // Later writes to a repeated address win
      for (k = 0; k < N_EXT; k++) begin
         exp = wd[k];
         for (j = k + 1; j < N_EXT; j++)
            if (wa[j] == wa[k])
               exp = wd[j];
         issue_read(wa[k], exp);
         check_bit("ext.re", ext.re, 1'b1);
         check_word("ext.addr on read", ext.addr, wa[k]);
      end
      drain();
      // Untouched region 8000 to BFFF
      for (k = 0; k < 8; k++) begin
         r = rand_bits(14);
         a = {2'b10, r[13:0]};
         issue_read(a, fill_byte(a));
      end
      drain();
   endtask

   task automatic test_mem_disable();
      addr_t       a;
      logic [31:0] r;
      int          k;
      int          strobes;
      mem_disable = 1'b1;
      strobes     = ext_strobes;
      a           = 16'hc000;
      for (k = 0; k < 6; k++) begin
         r = rand_bits(13);
         a = {3'b110, r[12:0]};
         issue_write(a, 8'hc3);
         issue_read(a, 8'h00);
      end
      drain();
      // High RAM and IE keep working
      issue_write(16'hff90, 8'h3c);
      issue_write(ADDR_IE, 8'h0a);
      bus_idle();
      read_check(16'hff90, 8'h3c);
      read_check(ADDR_IE, 8'h0a);
      assert (ext_strobes == strobes)
         else fail_now("External strobe seen while external memory was disabled");
      mem_disable = 1'b0;
      // Dropped write left the model alone
      read_check(a, fill_byte(a));
   endtask

`endif

// File: verification/tb_top.sv
`timescale 1ns/10ps

module tb_top import gb80_pkg::*; ();

   // External accesses in the routing test
   localparam int N_EXT = 16;
   // Cycle budget for the HRAM and ext tests plus a few hundred for irq and disable
   localparam int CMD_COUNT   = 4 * HRAM_DEPTH + 8 * N_EXT + 400;
   localparam int WATCHDOG_NS = CMD_COUNT * 20 + 2000;

   logic     clock;
   logic     reset;
   bus_cmd_t cmd;
   logic     mem_disable;
   bus_rsp_t rsp;
   ext_bus_t ext;
   data_t    ext_rdata;
   irq_t     irq;
   logic     ime_set;
   logic     ime_clear;
   logic     ack;
   logic     irq_pending;
   data_t    vector;

   // 64 KB external memory model
   data_t       ext_mem [65536];
   logic [31:0] lfsr_state;
   int          cyc;
   int          ext_strobes;
   // Outstanding reads in issue order
   data_t       exp_data_q[$];
   addr_t       exp_addr_q[$];
   int          exp_cyc_q[$];

   gb80_bus_unit dut (
      .clock       (clock),
      .reset       (reset),
      .cmd         (cmd),
      .mem_disable (mem_disable),
      .rsp         (rsp),
      .ext         (ext),
      .ext_rdata   (ext_rdata),
      .irq         (irq),
      .ime_set     (ime_set),
      .ime_clear   (ime_clear),
      .ack         (ack),
      .irq_pending (irq_pending),
      .vector      (vector)
   );

   // Memory answers from the address pins and takes writes at the edge
   assign ext_rdata = ext_mem[ext.addr];

   always @(posedge clock) begin
      if (ext.we)
         ext_mem[ext.addr] = ext.wdata;
   end

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   initial begin
      #(WATCHDOG_NS);
      fail_now("Watchdog expired before the test sequence finished");
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string what, input data_t got, input data_t exp);
      assert (got === exp)
         else fail_now($sformatf("FAIL at %0d ns: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_word(input string what, input addr_t got, input addr_t exp);
      assert (got === exp)
         else fail_now($sformatf("FAIL at %0d ns: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      assert (got === exp)
         else fail_now($sformatf("FAIL at %0d ns: %s got %b expected %b", $time, what, got, exp));
   endtask

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      logic        fb;
      int          i;
      value = '0;
      for (i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         value      = {value[30:0], fb};
      end
      return value;
   endfunction

   // Uses every address bit
   function automatic data_t fill_byte(input addr_t a);
      return {a[11:8], a[15:12]} ^ a[7:0];
   endfunction

   // Position of the lowest set bit or 0 when none
   function automatic int lowest_bit(input irq_t p);
      int low;
      int n;
      low = 0;
      for (n = 4; n >= 0; n--)
         if (p[n])
            low = n;
      return low;
   endfunction

   // One clock and a look at the outputs before new inputs go in
   task automatic next_cycle();
      data_t exp;
      int    lat;
      @(posedge clock);
      #1;
      cyc++;
      if (ext.re || ext.we)
         ext_strobes++;
      if (rsp.valid) begin
         assert (exp_data_q.size() != 0)
            else fail_now("Read response arrived with no read outstanding");
         exp = exp_data_q.pop_front();
         lat = cyc - exp_cyc_q.pop_front();
         check_byte($sformatf("read %h", exp_addr_q.pop_front()), rsp.data, exp);
         check_byte("read latency", data_t'(lat), 8'd2);
      end
   endtask

   task automatic issue_read(input addr_t a, input data_t exp);
      cmd = '{rd: 1'b1, wr: 1'b0, addr: a, wdata: 8'h00};
      exp_addr_q.push_back(a);
      exp_data_q.push_back(exp);
      exp_cyc_q.push_back(cyc);
      next_cycle();
   endtask

   task automatic issue_write(input addr_t a, input data_t d);
      cmd = '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
      next_cycle();
   endtask

   task automatic bus_idle();
      cmd = '0;
      next_cycle();
   endtask

   // Wait out every outstanding read
   task automatic drain();
      int waited;
      waited = 0;
      cmd    = '0;
      while (exp_data_q.size() != 0) begin
         assert (waited < 8)
            else fail_now("Read response did not arrive in time");
         next_cycle();
         waited++;
      end
   endtask

   task automatic read_check(input addr_t a, input data_t exp);
      issue_read(a, exp);
      drain();
   endtask

`include "tb_tests.svh"

   initial begin
      int a;
      for (a = 0; a < 65536; a++)
         ext_mem[a] = fill_byte(addr_t'(a));
      lfsr_state  = 32'h9755c410;
      cyc         = 0;
      ext_strobes = 0;
      cmd         = '0;
      mem_disable = 1'b0;
      irq         = '0;
      ime_set     = 1'b0;
      ime_clear   = 1'b0;
      ack         = 1'b0;
      reset       = 1'b1;
      repeat (4) @(posedge clock);
      #1;
      reset = 1'b0;
      test_irq_flags();
      test_irq_ack_mask();
      test_hram();
      test_ext_routing();
      test_mem_disable();
      bus_idle();
      bus_idle();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: verification/gb80_bus_asserts.sv
`timescale 1ns/10ps

module gb80_bus_asserts import gb80_pkg::*; (
   input logic     clock,
   input logic     reset,
   input bus_cmd_t cmd,
   input bus_rsp_t rsp,
   input ext_bus_t ext,
   input logic     irq_pending,
   input logic     ime_set,
   input logic     ime_clear
);

   // Outside memory never sees read and write together
   ext_strobe_excl: assert property (@(posedge clock) disable iff (reset)
      !(ext.re && ext.we))
      else $error("ext.re and ext.we high in the same cycle");

   // Every read answered two cycles later
   read_answered: assert property (@(posedge clock) disable iff (reset)
      cmd.rd |-> ##2 rsp.valid)
      else $error("read without a response two cycles later");

   // No response without a read
   rsp_from_read: assert property (@(posedge clock) disable iff (reset)
      rsp.valid |-> $past(cmd.rd, 2))
      else $error("response without a read two cycles earlier");

   // Clearing the master enable drops the request line
   pending_needs_ime: assert property (@(posedge clock) disable iff (reset)
      (ime_clear && !ime_set) |=> !irq_pending)
      else $error("irq_pending high after IME was cleared");

endmodule

bind gb80_bus_unit gb80_bus_asserts u_bus_asserts (
   .clock       (clock),
   .reset       (reset),
   .cmd         (cmd),
   .rsp         (rsp),
   .ext         (ext),
   .irq_pending (irq_pending),
   .ime_set     (ime_set),
   .ime_clear   (ime_clear)
);

// File: rtl/gb80_bus_unit.sv
`timescale 1ns/10ps

module gb80_bus_unit import gb80_pkg::*; (
   input  logic     clock,
   input  logic     reset,
   input  bus_cmd_t cmd,
   input  logic     mem_disable,
   output bus_rsp_t rsp,
   output ext_bus_t ext,
   input  data_t    ext_rdata,
   input  irq_t     irq,
   input  logic     ime_set,
   input  logic     ime_clear,
   input  logic     ack,
   output logic     irq_pending,
   output data_t    vector
);

   // Requests from the decoder to each peer
   hram_req_t hram_req;
   reg_req_t  reg_req;
   bus_cmd_t  ext_cmd;

   // Read data coming back, one cycle after the request
   data_t hram_rdata;
   data_t reg_rdata;
   data_t ext_rdata_q;

   addr_decode u_addr_decode (
      .clock       (clock),
      .reset       (reset),
      .cmd         (cmd),
      .mem_disable (mem_disable),
      .hram_req    (hram_req),
      .reg_req     (reg_req),
      .ext_cmd     (ext_cmd),
      .hram_rdata  (hram_rdata),
      .reg_rdata   (reg_rdata),
      .ext_rdata_q (ext_rdata_q),
      .rsp         (rsp)
   );

   hram u_hram (
      .clock    (clock),
      .reset    (reset),
      .hram_req (hram_req),
      .rdata    (hram_rdata)
   );

   interrupt_ctrl u_interrupt_ctrl (
      .clock       (clock),
      .reset       (reset),
      .reg_req     (reg_req),
      .irq         (irq),
      .ime_set     (ime_set),
      .ime_clear   (ime_clear),
      .ack         (ack),
      .rdata       (reg_rdata),
      .irq_pending (irq_pending),
      .vector      (vector)
   );

   ext_mem_port u_ext_mem_port (
      .clock     (clock),
      .reset     (reset),
      .ext_cmd   (ext_cmd),
      .ext       (ext),
      .ext_rdata (ext_rdata),
      .rdata     (ext_rdata_q)
   );

endmodule

// File: rtl/ext_mem_port.sv
`timescale 1ns/10ps

module ext_mem_port import gb80_pkg::*; (
   input  logic     clock,
   input  logic     reset,
   input  bus_cmd_t ext_cmd,
   output ext_bus_t ext,
   input  data_t    ext_rdata,
   output data_t    rdata
);

   // Strobes and address come straight from the request registers
   // Write data only driven while writing
   always_comb begin
      ext.re    = ext_cmd.rd;
      ext.we    = ext_cmd.wr;
      ext.addr  = ext_cmd.addr;
      ext.wdata = ext_cmd.wr ? ext_cmd.wdata : '0;
   end

   // Memory answers combinationally from ext.addr
   // Capture at the end of the read cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset)
         rdata <= '0;
      else if (ext.re)
         rdata <= ext_rdata;
   end

endmodule

// File: interrupt/interrupt_ctrl.sv
`timescale 1ns/10ps

module interrupt_ctrl import gb80_pkg::*; (
   input  logic     clock,
   input  logic     reset,
   input  reg_req_t reg_req,
   input  irq_t     irq,
   input  logic     ime_set,
   input  logic     ime_clear,
   input  logic     ack,
   output data_t    rdata,
   output logic     irq_pending,
   output data_t    vector
);

   irq_t       if_q;
   irq_t       ie_q;
   logic       ime_q;
   irq_t       pend;
   logic       irq_any;
   logic [2:0] irq_sel;
   irq_t       ack_clr;
   irq_t       if_next;

   // Enabled and requested
   assign pend    = if_q & ie_q;
   assign irq_any = |pend;

   // Priority encoder, lowest bit first
   always_comb begin
      irq_sel = IRQ_VBLANK;
      if (pend[IRQ_VBLANK])
         irq_sel = IRQ_VBLANK;
      else if (pend[IRQ_LCDC])
         irq_sel = IRQ_LCDC;
      else if (pend[IRQ_TIMA])
         irq_sel = IRQ_TIMA;
      else if (pend[IRQ_SERIAL])
         irq_sel = IRQ_SERIAL;
      else if (pend[IRQ_HILO])
         irq_sel = IRQ_HILO;
   end

   // Acknowledge clears only the bit being served
   always_comb begin
      ack_clr = '0;
      if (ack && irq_any)
         ack_clr[irq_sel] = 1'b1;
   end

   // 40h, 48h, 50h, 58h, 60h
   assign vector      = irq_any ? (VECTOR_BASE + data_t'(irq_sel) * VECTOR_STRIDE) : '0;
   assign irq_pending = ime_q && irq_any;

   // Bus write first, then ack, then new requests
   always_comb begin
      if_next = if_q;
      if (reg_req.wr && !reg_req.sel_ie)
         if_next = reg_req.wdata[4:0];
      if_next = if_next & ~ack_clr;
      if_next = if_next | irq;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q  <= '0;
         ie_q  <= '0;
         ime_q <= 1'b1;
         rdata <= '0;
      end else begin
         if_q <= if_next;
         if (reg_req.wr && reg_req.sel_ie)
            ie_q <= reg_req.wdata[4:0];
         // Master enable, set wins over clear
         if (ime_set)
            ime_q <= 1'b1;
         else if (ime_clear)
            ime_q <= 1'b0;
         // Upper three bits read as zero
         if (reg_req.rd)
            rdata <= reg_req.sel_ie ? {3'b000, ie_q} : {3'b000, if_q};
      end
   end

endmodule

// File: hram/hram.sv
`timescale 1ns/10ps

module hram import gb80_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  hram_req_t hram_req,
   output data_t     rdata
);

   // 127 bytes, FF80 to FFFE
   data_t mem [HRAM_DEPTH];

   // Write port
   always_ff @(posedge clock) begin
      if (hram_req.wr)
         mem[hram_req.offset] <= hram_req.wdata;
   end

   // Registered read, holds the last byte between reads
   always_ff @(posedge clock or posedge reset) begin
      if (reset)
         rdata <= '0;
      else if (hram_req.rd)
         rdata <= mem[hram_req.offset];
   end

endmodule

// File: rtl/addr_decode.sv
`timescale 1ns/10ps

module addr_decode import gb80_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  bus_cmd_t  cmd,
   input  logic      mem_disable,
   output hram_req_t hram_req,
   output reg_req_t  reg_req,
   output bus_cmd_t  ext_cmd,
   input  data_t     hram_rdata,
   input  data_t     reg_rdata,
   input  data_t     ext_rdata_q,
   output bus_rsp_t  rsp
);

   target_e tgt;
   // Strobes, one peer at a time
   logic    hram_rd_q, hram_wr_q;
   logic    reg_rd_q, reg_wr_q;
   logic    ext_rd_q, ext_wr_q;
   // Shared payload for whichever peer is addressed
   addr_t   addr_q;
   data_t   wdata_q;
   logic    sel_ie_q;
   addr_t   hram_off;
   // Read tracking, stage 1 lines up with the request, stage 2 with the data
   logic    rd_q1, rd_q2;
   target_e rd_tgt_q1, rd_tgt_q2;

   // Address map
   always_comb begin
      if ((cmd.addr >= HRAM_BASE) && (cmd.addr <= HRAM_END))
         tgt = TGT_HRAM;
      else if (cmd.addr == ADDR_IF)
         tgt = TGT_IF;
      else if (cmd.addr == ADDR_IE)
         tgt = TGT_IE;
      else if (mem_disable)
         tgt = TGT_NONE;
      else
         tgt = TGT_EXT;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         hram_rd_q <= 1'b0;
         hram_wr_q <= 1'b0;
         reg_rd_q  <= 1'b0;
         reg_wr_q  <= 1'b0;
         ext_rd_q  <= 1'b0;
         ext_wr_q  <= 1'b0;
         rd_q1     <= 1'b0;
         rd_q2     <= 1'b0;
      end else begin
         hram_rd_q <= cmd.rd && (tgt == TGT_HRAM);
         hram_wr_q <= cmd.wr && (tgt == TGT_HRAM);
         reg_rd_q  <= cmd.rd && ((tgt == TGT_IF) || (tgt == TGT_IE));
         reg_wr_q  <= cmd.wr && ((tgt == TGT_IF) || (tgt == TGT_IE));
         ext_rd_q  <= cmd.rd && (tgt == TGT_EXT);
         ext_wr_q  <= cmd.wr && (tgt == TGT_EXT);
         // Every read gets an answer, TGT_NONE included
         rd_q1     <= cmd.rd;
         rd_q2     <= rd_q1;
      end
   end

   always_ff @(posedge clock) begin
      if (cmd.rd || cmd.wr) begin
         addr_q   <= cmd.addr;
         wdata_q  <= cmd.wdata;
         sel_ie_q <= (tgt == TGT_IE);
      end
      rd_tgt_q1 <= tgt;
      rd_tgt_q2 <= rd_tgt_q1;
   end

   // Offset into high RAM, upper bits are zero inside the window
   assign hram_off = addr_q - HRAM_BASE;

   assign hram_req = '{rd: hram_rd_q, wr: hram_wr_q, offset: hram_off[6:0], wdata: wdata_q};
   assign reg_req  = '{rd: reg_rd_q, wr: reg_wr_q, sel_ie: sel_ie_q, wdata: wdata_q};
   assign ext_cmd  = '{rd: ext_rd_q, wr: ext_wr_q, addr: addr_q, wdata: wdata_q};

   // Return mux, reads to nowhere give zero
   always_comb begin
      rsp.valid = rd_q2;
      case (rd_tgt_q2)
         TGT_HRAM: rsp.data = hram_rdata;
         TGT_IF:   rsp.data = reg_rdata;
         TGT_IE:   rsp.data = reg_rdata;
         TGT_EXT:  rsp.data = ext_rdata_q;
         default:  rsp.data = '0;
      endcase
   end

endmodule

// File: common/gb80_pkg.sv
package gb80_pkg;

   // Basic widths of the memory-side bus
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;
   // One bit per interrupt source
   typedef logic [4:0]  irq_t;
   // Offset inside high RAM
   typedef logic [6:0]  hram_addr_t;

   // High RAM window, FFFF is taken by IE
   localparam addr_t HRAM_BASE  = 16'hff80;
   localparam addr_t HRAM_END   = 16'hfffe;
   localparam int    HRAM_DEPTH = 127;

   // Interrupt registers on the memory map
   localparam addr_t ADDR_IF = 16'hff0f;
   localparam addr_t ADDR_IE = 16'hffff;

   // Interrupt bit positions, bit 0 wins
   localparam logic [2:0] IRQ_VBLANK = 3'd0;
   localparam logic [2:0] IRQ_LCDC   = 3'd1;
   localparam logic [2:0] IRQ_TIMA   = 3'd2;
   localparam logic [2:0] IRQ_SERIAL = 3'd3;
   localparam logic [2:0] IRQ_HILO   = 3'd4;

   // Handler address is base plus stride times bit number
   localparam data_t VECTOR_BASE   = 8'h40;
   localparam data_t VECTOR_STRIDE = 8'd8;

   // Peer that answers an access
   typedef enum logic [2:0] {
      TGT_EXT,
      TGT_HRAM,
      TGT_IF,
      TGT_IE,
      TGT_NONE
   } target_e;

   // Command from the sequencer, also the request toward the external port
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      data_t wdata;
   } bus_cmd_t;

   // Read return
   typedef struct packed {
      logic  valid;
      data_t data;
   } bus_rsp_t;

   typedef struct packed {
      logic       rd;
      logic       wr;
      hram_addr_t offset;
      data_t      wdata;
   } hram_req_t;

   // IF / IE access, sel_ie picks IE
   typedef struct packed {
      logic  rd;
      logic  wr;
      logic  sel_ie;
      data_t wdata;
   } reg_req_t;

   // Pins toward the outside memory
   typedef struct packed {
      logic  re;
      logic  we;
      addr_t addr;
      data_t wdata;
   } ext_bus_t;

endpackage
